// File: source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath sizes
`define CPU_DATA_W      32
`define CPU_REG_N       32
`define CPU_JUMP_W      28

// cycles wait_sig stays up per memory access
`define CPU_MEM_WAIT    5

// instruction word fields
`define CPU_OP_HI       31
`define CPU_OP_LO       26
`define CPU_RS_HI       25
`define CPU_RS_LO       21
`define CPU_RT_HI       20
`define CPU_RT_LO       16
`define CPU_RD_HI       15
`define CPU_RD_LO       11
`define CPU_SH_HI       10
`define CPU_SH_LO       6
`define CPU_FN_HI       5
`define CPU_FN_LO       0
`define CPU_IMM_HI      15
`define CPU_JADDR_HI    25

`endif

// File: source/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [4:0]             reg_num_t;
    typedef logic [4:0]             shamt_t;
    typedef logic [15:0]            imm_t;
    typedef logic [`CPU_JUMP_W-1:0] jump_target_t;

    // kept opcodes only, anything else halts
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_SLLV    = 6'h04,
        FN_SRLV    = 6'h06,
        FN_SYSCALL = 6'h0c,
        FN_ADD     = 6'h20,
        FN_ADDU    = 6'h21,
        FN_SUB     = 6'h22,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_EQ
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        MEM_WAIT,
        HALTED
    } exec_state_e;

endpackage

// File: source/inst_decoder.sv
`include "cpu_defines.svh"

module inst_decoder import cpu_pkg::*; (
    input  word_t    inst,
    output reg_num_t rs_num,
    output reg_num_t rt_num,
    output reg_num_t rd_num,
    output shamt_t   shamt,
    output imm_t     imm,
    output word_t    jump_field,
    output alu_op_e  alu_op,
    output logic     b_is_imm,
    output logic     imm_signed,
    output logic     shift_by_shamt,
    output logic     shift_rt_first,
    output logic     is_lui,
    output logic     reg_write,
    output logic     dest_is_rt,
    output logic     is_load,
    output logic     is_store,
    output logic     is_beq,
    output logic     is_bne,
    output logic     is_jump,
    output logic     is_halt
);

    assign rs_num = inst[`CPU_RS_HI:`CPU_RS_LO];
    assign rt_num = inst[`CPU_RT_HI:`CPU_RT_LO];
    assign rd_num = inst[`CPU_RD_HI:`CPU_RD_LO];
    assign shamt  = inst[`CPU_SH_HI:`CPU_SH_LO];
    assign imm    = inst[`CPU_IMM_HI:0];

    // 26-bit target already shifted into byte address
    assign jump_field = {{(`CPU_DATA_W - `CPU_JUMP_W){1'b0}}, inst[`CPU_JADDR_HI:0], 2'b00};

    always_comb begin
        alu_op         = ALU_ADD;
        b_is_imm       = 1'b0;
        imm_signed     = 1'b0;
        shift_by_shamt = 1'b0;
        shift_rt_first = 1'b0;
        is_lui         = 1'b0;
        reg_write      = 1'b0;
        dest_is_rt     = 1'b0;
        is_load        = 1'b0;
        is_store       = 1'b0;
        is_beq         = 1'b0;
        is_bne         = 1'b0;
        is_jump        = 1'b0;
        is_halt        = 1'b0;

        case (opcode_e'(inst[`CPU_OP_HI:`CPU_OP_LO]))
            OP_RTYPE: begin
                reg_write = 1'b1;   // cleared again below for halts
                case (funct_e'(inst[`CPU_FN_HI:`CPU_FN_LO]))
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        shift_by_shamt = 1'b1;
                        shift_rt_first = 1'b1;
                        alu_op = (inst[1:0] == 2'b00) ? ALU_SLL :
                                 (inst[1:0] == 2'b10) ? ALU_SRL : ALU_SRA;
                    end
                    FN_SLLV, FN_SRLV: begin
                        shift_rt_first = 1'b1;   // rt shifted by rs
                        alu_op = inst[1] ? ALU_SRL : ALU_SLL;
                    end
                    FN_SYSCALL: begin
                        reg_write = 1'b0;
                        is_halt   = 1'b1;
                    end
                    default: begin
                        reg_write = 1'b0;   // unknown funct halts too
                        is_halt   = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                b_is_imm   = 1'b1;
                imm_signed = 1'b1;
                reg_write  = 1'b1;
                dest_is_rt = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                b_is_imm   = 1'b1;
                reg_write  = 1'b1;
                dest_is_rt = 1'b1;
                alu_op = (inst[27:26] == 2'b00) ? ALU_AND :
                         (inst[27:26] == 2'b01) ? ALU_OR : ALU_XOR;
            end
            OP_LUI: begin
                is_lui     = 1'b1;
                reg_write  = 1'b1;
                dest_is_rt = 1'b1;
            end
            OP_BEQ: begin
                alu_op = ALU_EQ;
                is_beq = 1'b1;
            end
            OP_BNE: begin
                alu_op = ALU_EQ;
                is_bne = 1'b1;
            end
            OP_J:    is_jump  = 1'b1;
            OP_LW:   is_load  = 1'b1;
            OP_SW:   is_store = 1'b1;
            default: is_halt  = 1'b1;
        endcase
    end

endmodule

// File: source/reg_file.sv
`include "cpu_defines.svh"

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  reg_num_t rs_num,
    input  reg_num_t rt_num,
    input  reg_num_t wr_num,
    input  word_t    wr_data,
    input  logic     wr_en,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [`CPU_REG_N];

    // async reads, same-cycle write not forwarded
    assign rs_data = regs[rs_num];
    assign rt_data = regs[rt_num];

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < `CPU_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_num != '0)) begin
            regs[wr_num] <= wr_data;   // $zero never written
        end
    end

endmodule

// File: source/alu.sv
module alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    logic [4:0] sh;

    assign sh = b[4:0];   // shift count from low bits only

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            ALU_SLL: result = a << sh;
            ALU_SRL: result = a >> sh;
            ALU_SRA: result = word_t'($signed(a) >>> sh);
            ALU_SLT: begin
                // signed compare, 1 or 0
                result = word_t'($signed(a) < $signed(b));
            end
            ALU_EQ:  result = word_t'(a == b);   // branch compare
            default: result = '0;
        endcase
    end

endmodule

// File: source/exec_datapath.sv
`include "cpu_defines.svh"

module exec_datapath import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_b,
    input  reg_num_t     rs_num,
    input  reg_num_t     rt_num,
    input  reg_num_t     rd_num,
    input  shamt_t       shamt,
    input  imm_t         imm,
    input  word_t        jump_field,
    input  alu_op_e      alu_op,
    input  logic         b_is_imm,
    input  logic         imm_signed,
    input  logic         shift_by_shamt,
    input  logic         shift_rt_first,
    input  logic         is_lui,
    input  logic         reg_write,
    input  logic         dest_is_rt,
    input  logic         is_load,
    input  logic         is_store,
    input  logic         is_beq,
    input  logic         is_bne,
    input  logic         is_jump,
    input  logic         exec_accept,
    input  logic         load_done,
    input  word_t        mem_rdata,
    output word_t        mem_addr,
    output word_t        mem_wdata,
    output logic         mem_write_en,
    output word_t        pc_branch,
    output logic         pc_branch_en,
    output jump_target_t pc_j,
    output logic         pc_j_en
);

    word_t    rs_data, rt_data, alu_a, alu_b, alu_result;
    word_t    imm_sext, imm_ext, wr_data, branch_target;
    reg_num_t wr_num, load_num;
    logic     wr_en, branch_taken;

    assign imm_sext = {{(`CPU_DATA_W - 16){imm[15]}}, imm};
    assign imm_ext  = imm_signed ? imm_sext : {{(`CPU_DATA_W - 16){1'b0}}, imm};

    // shifts put rt on A, amount comes from shamt or rs
    assign alu_a = shift_rt_first ? rt_data : rs_data;
    assign alu_b = shift_by_shamt ? word_t'(shamt) :
                   b_is_imm       ? imm_ext :
                   shift_rt_first ? rs_data : rt_data;

    // a finishing load owns the write port, no accept can overlap it
    assign wr_en   = load_done || (exec_accept && reg_write);
    assign wr_num  = load_done ? load_num : (dest_is_rt ? rt_num : rd_num);
    assign wr_data = load_done ? mem_rdata :
                     is_lui    ? {imm, 16'b0} : alu_result;

    assign branch_taken  = (is_beq && alu_result[0]) || (is_bne && !alu_result[0]);
    assign branch_target = (imm_sext << 2) + word_t'(4);

    reg_file i_reg_file (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .wr_num  (wr_num),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    // one-cycle strobes
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            mem_write_en <= 1'b0;
            pc_branch_en <= 1'b0;
            pc_j_en      <= 1'b0;
        end else begin
            mem_write_en <= exec_accept && is_store;
            pc_branch_en <= exec_accept && branch_taken;
            pc_j_en      <= exec_accept && is_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_accept && (is_load || is_store)) begin
            mem_addr  <= rs_data + imm_sext;   // held for whole wait window
            mem_wdata <= rt_data;
            load_num  <= rt_num;
        end
        if (exec_accept && branch_taken) pc_branch <= branch_target;
        if (exec_accept && is_jump)      pc_j      <= jump_field[`CPU_JUMP_W-1:0];
    end

endmodule

// File: source/exec_control.sv
module exec_control import cpu_pkg::*; (
    input  logic clk,
    input  logic rst_b,
    input  logic inst_valid,
    input  logic is_load,
    input  logic is_store,
    input  logic is_halt,
    input  logic wait_done,
    output logic exec_accept,
    output logic mem_start,
    output logic load_done,
    output logic wait_sig,
    output logic halted
);

    exec_state_e state, state_next;
    logic        load_pending;   // current access is lw

    // inst_valid only counts in IDLE
    assign exec_accept = (state == IDLE) && inst_valid;
    assign mem_start   = exec_accept && (is_load || is_store);
    assign load_done   = (state == MEM_WAIT) && wait_done && load_pending;

    assign wait_sig = (state == MEM_WAIT);
    assign halted   = (state == HALTED);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (exec_accept && is_halt) begin
                    state_next = HALTED;
                end else if (mem_start) begin
                    state_next = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (wait_done) begin
                    state_next = IDLE;
                end
            end
            HALTED:  state_next = HALTED;   // only reset gets out
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            state        <= IDLE;
            load_pending <= 1'b0;
        end else begin
            state <= state_next;
            if (mem_start) begin
                load_pending <= is_load;
            end
        end
    end

endmodule

// File: source/mem_wait_timer.sv
`include "cpu_defines.svh"

module mem_wait_timer (
    input  logic clk,
    input  logic rst_b,
    input  logic start,
    output logic wait_done
);

    localparam int CNT_W = $clog2(`CPU_MEM_WAIT + 1);

    logic [CNT_W-1:0] remaining;   // cycles left in window, 0 when idle

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            remaining <= '0;
        end else if (start) begin
            remaining <= CNT_W'(`CPU_MEM_WAIT);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign wait_done = (remaining == CNT_W'(1));   // last cycle of window

endmodule

// File: source/cpu_core.sv
module cpu_core import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_b,
    input  word_t        inst,
    input  logic         inst_valid,
    input  word_t        mem_rdata,
    output word_t        mem_addr,
    output word_t        mem_wdata,
    output logic         mem_write_en,
    output logic         wait_sig,
    output logic         halted,
    output word_t        pc_branch,
    output logic         pc_branch_en,
    output jump_target_t pc_j,
    output logic         pc_j_en
);

    // decoder outputs, same names on the datapath ports
    reg_num_t rs_num, rt_num, rd_num;
    shamt_t   shamt;
    imm_t     imm;
    word_t    jump_field;
    alu_op_e  alu_op;
    logic     b_is_imm, imm_signed, shift_by_shamt, shift_rt_first;
    logic     is_lui, reg_write, dest_is_rt;
    logic     is_load, is_store, is_beq, is_bne, is_jump, is_halt;

    logic     exec_accept, mem_start, load_done, wait_done;

    inst_decoder i_inst_decoder (.*);

    exec_control i_exec_control (
        .clk         (clk),
        .rst_b       (rst_b),
        .inst_valid  (inst_valid),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_halt     (is_halt),
        .wait_done   (wait_done),
        .exec_accept (exec_accept),
        .mem_start   (mem_start),
        .load_done   (load_done),
        .wait_sig    (wait_sig),
        .halted      (halted)
    );

    mem_wait_timer i_mem_wait_timer (
        .clk       (clk),
        .rst_b     (rst_b),
        .start     (mem_start),
        .wait_done (wait_done)
    );

    exec_datapath i_exec_datapath (.*);

endmodule

// File: tb/cpu_checker.sv
`include "cpu_defines.svh"

module cpu_checker import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_b,
    input  logic         inst_valid,
    input  logic         wait_sig,
    input  logic         halted,
    input  word_t        mem_addr,
    input  word_t        mem_wdata,
    input  logic         mem_write_en,
    input  word_t        pc_branch,
    input  logic         pc_branch_en,
    input  jump_target_t pc_j,
    input  logic         pc_j_en,
    output int           errors,
    output int           n_accepted
);

    timeunit 1ns;
    timeprecision 1ns;

    string names[$], kinds[$];
    word_t exp_a[$], exp_b[$];
    bit    mem_ops[$];   // lw or sw, from the opcode field
    string cur_name = "reset";
    string cur_kind = "";   // expectation for the cycle after an accept
    word_t cur_a, cur_b;
    bit    cur_mem = 1'b0;
    bit    in_reset = 1'b0;
    bit    halt_seen = 1'b0;
    int    wait_len = 0;

    initial begin
        int    fd, rc;
        string line, nm, kd;
        word_t w, a, b;
        errors     = 0;
        n_accepted = 0;
        fd = $fopen("tb/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("checker cannot open tb/cpu_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line[0] != "#" &&
                    $sscanf(line, "%s %h %s %h %h", nm, w, kd, a, b) == 5) begin
                    names.push_back(nm);
                    kinds.push_back(kd);
                    exp_a.push_back(a);
                    exp_b.push_back(b);
                    mem_ops.push_back(w[31:26] == 6'h23 || w[31:26] == 6'h2b);
                end
            end
            $fclose(fd);
        end
    end

    task automatic report(string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare(string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h actual %h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_strobe(string strobe, string what, logic seen, logic want,
                                word_t exp, word_t act);
        if (want && !seen) begin
            report($sformatf("no %s pulse after %s", strobe, cur_name));
        end else if (seen && !want) begin
            report($sformatf("unexpected %s pulse after %s", strobe, cur_name));
        end else if (seen) begin
            compare(what, exp, act);
        end
    endtask

    // sampled at the rising edge, so each value is the one of the cycle just ending
    always @(posedge clk) begin
        if (!rst_b) begin
            if (in_reset && (wait_sig || halted || mem_write_en || pc_branch_en || pc_j_en)) begin
                report("outputs still active during reset");
            end
            in_reset  = 1'b1;
            halt_seen = 1'b0;
            wait_len  = 0;
            cur_kind  = "";
            cur_mem   = 1'b0;
        end else begin
            in_reset = 1'b0;
            check_strobe("mem_write_en", "mem_addr", mem_write_en, cur_kind == "store",
                         cur_a, mem_addr);
            if (mem_write_en && cur_kind == "store") begin
                compare("mem_wdata", cur_b, mem_wdata);
            end
            check_strobe("pc_branch_en", "pc_branch", pc_branch_en, cur_kind == "branch",
                         cur_a, pc_branch);
            check_strobe("pc_j_en", "pc_j", pc_j_en, cur_kind == "jump", cur_a, word_t'(pc_j));

            if (halted && !halt_seen && cur_kind != "halt") begin
                report($sformatf("halted rose without a halting instruction after %s", cur_name));
            end
            if (!halted && cur_kind == "halt") begin
                report($sformatf("halted did not rise after %s", cur_name));
            end
            if (!halted && halt_seen) begin
                report("halted dropped before reset");
            end
            halt_seen = halted;

            if (cur_mem && !wait_sig) begin
                report($sformatf("wait_sig did not rise after %s", cur_name));
            end
            if (!cur_mem && wait_sig && wait_len == 0) begin
                report($sformatf("wait_sig rose without a memory access after %s", cur_name));
            end
            if (wait_sig) begin
                wait_len++;
            end else if (wait_len != 0) begin
                compare("wait_sig cycles", `CPU_MEM_WAIT, wait_len);
                wait_len = 0;
            end

            cur_kind = "";
            cur_mem  = 1'b0;
            if (inst_valid && !wait_sig && !halted) begin   // accepted at this edge
                if (n_accepted >= names.size()) begin
                    report("instruction accepted beyond the end of the stimulus");
                end else begin
                    cur_name = names[n_accepted];
                    cur_kind = kinds[n_accepted];
                    cur_a    = exp_a[n_accepted];
                    cur_b    = exp_b[n_accepted];
                    cur_mem  = mem_ops[n_accepted];
                end
                n_accepted++;
            end
        end
    end

endmodule

// File: tb/tb_cpu_core.sv
`include "cpu_defines.svh"

module tb_cpu_core import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int    MEM_WORDS = 2048;
    localparam word_t STRAY_SW  = 32'hAC01011C;   // sw $1,0x11c($0), must be ignored

    logic         clk = 1'b0;
    logic         rst_b, inst_valid, mem_write_en, wait_sig, halted;
    logic         pc_branch_en, pc_j_en;
    word_t        inst, mem_rdata, mem_addr, mem_wdata, pc_branch;
    jump_target_t pc_j;
    word_t        mem [MEM_WORDS];
    word_t        words[$];
    string        kinds[$];
    logic [31:0]  rnd = 32'd13151;
    int           errors, n_accepted;
    bit           loaded = 1'b0;

    always #50 clk = ~clk;

    cpu_core i_dut (.*);

    cpu_checker i_checker (.*);

    // word model, rule value outside the modelled window
    assign mem_rdata = (mem_addr < MEM_WORDS * 4) ? mem[mem_addr[12:2]]
                                                  : (mem_addr ^ 32'h5A5A0000);

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'h5A5A0000;
        end
    end

    always @(posedge clk) begin
        if (mem_write_en && (mem_addr < MEM_WORDS * 4)) begin
            mem[mem_addr[12:2]] <= mem_wdata;
        end
    end

    function automatic logic [31:0] next_random(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic read_stimulus();
        int    fd, rc;
        string line, name, kind;
        word_t word, exp_a, exp_b;
        fd = $fopen("tb/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/cpu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line[0] != "#" &&
                    $sscanf(line, "%s %h %s %h %h", name, word, kind, exp_a, exp_b) == 5) begin
                    words.push_back(word);
                    kinds.push_back(kind);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        rst_b = 1'b0;
        repeat (4) @(negedge clk);
        rst_b = 1'b1;
    endtask

    task automatic finish_run();
        int total;
        total = errors;
        if (words.size() == 0) begin
            $display("no instructions were read from the stimulus file");
            total++;
        end
        if (n_accepted != words.size()) begin
            $display("only %0d of %0d instructions were accepted", n_accepted, words.size());
            total++;
        end
        $display("instructions accepted: %0d, errors: %0d", n_accepted, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        rst_b      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        read_stimulus();
        loaded = 1'b1;
        apply_reset();
        foreach (words[i]) begin
            rnd = next_random(rnd);
            repeat (rnd % 4) @(negedge clk);   // 0 to 3 idle cycles
            while (wait_sig || halted) @(negedge clk);
            inst       = words[i];
            inst_valid = 1'b1;
            @(negedge clk);
            inst_valid = 1'b0;
            if (kinds[i] == "halt") begin
                // pulses while halted, then wake the core up again
                repeat (2) begin
                    inst       = STRAY_SW;
                    inst_valid = 1'b1;
                    @(negedge clk);
                    inst_valid = 1'b0;
                    @(negedge clk);
                end
                apply_reset();
            end
        end
        repeat (`CPU_MEM_WAIT + 3) @(negedge clk);
        finish_run();
    end

    // worst case per line is gap, accept and a full memory wait
    initial begin
        wait (loaded);
        repeat (words.size() * (`CPU_MEM_WAIT + 6) + 20) @(posedge clk);
        $display("watchdog expired before the stimulus was done");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/cpu_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/exec_datapath.sv
source/exec_control.sv
source/mem_wait_timer.sv
source/cpu_core.sv
tb/cpu_checker.sv
tb/tb_cpu_core.sv

// File: tb/cpu_stimulus.txt
# name instruction check expected_a expected_b (hex, unused columns 0)
# store: a is mem_addr, b is mem_wdata; branch: a is pc_branch; jump: a is pc_j
addi_r1        20011234 none     00000000 00000000
addiu_r2       2422FFF0 none     00000000 00000000
sw_addiu       AC020100 store    00000100 00001224
lui_r3         3C03F0F0 none     00000000 00000000
ori_r3         34638421 none     00000000 00000000
andi_r4        3064FF0F none     00000000 00000000
xori_r4        38848001 none     00000000 00000000
xor_r5         00642826 none     00000000 00000000
sw_logic_imm   AC050104 store    00000104 F0F08021
add_r6         00453020 none     00000000 00000000
sub_r7         00C13822 none     00000000 00000000
addu_r7        00E73821 none     00000000 00000000
subu_r7        00E23823 none     00000000 00000000
sw_arith       AC070108 store    00000108 E1E0EDFE
and_r8         00674024 none     00000000 00000000
nor_r9         01024827 none     00000000 00000000
or_r9          01244825 none     00000000 00000000
sw_logic       AC09010C store    0000010C 1F1F6DDB
slt_true_r10   00E1502A none     00000000 00000000
sll_r11        000A5FC0 none     00000000 00000000
sra_r12        000B6103 none     00000000 00000000
srl_r12        000C6202 none     00000000 00000000
sllv_r13       014C6804 none     00000000 00000000
srlv_r13       004D6806 none     00000000 00000000
slt_false_r14  0027702A none     00000000 00000000
or_r13         01AE6825 none     00000000 00000000
sw_shift       AC0D0110 store    00000110 001F0000
lw_r15         8C2FFFF0 none     00000000 00000000
sw_load        AC0F0114 store    00000114 5A5A1224
beq_taken      10210010 branch   00000044 00000000
beq_not_taken  10220010 nobranch 00000000 00000000
bne_taken      1422FFFE branch   FFFFFFFC 00000000
bne_not_taken  14630008 nobranch 00000000 00000000
jump           0AABCDEF jump     0AAF37BC 00000000
syscall        0000000C halt     00000000 00000000
sw_after_reset AC010118 store    00000118 00000000
bad_opcode     FC000000 halt     00000000 00000000
